//--- src/fcPkg.sv
// shared command codes, one-hot indices and sizes of the fast-command receive path, used by scoped name
package fcPkg;

	//////////////////////////////
	// fast command words
	//////////////////////////////
	localparam logic [7:0] CMD_IDLE       = 8'b1111_0000;
	localparam logic [7:0] CMD_LINK_RST   = 8'b1111_1000;
	localparam logic [7:0] CMD_BCR        = 8'b1111_0001;
	localparam logic [7:0] CMD_SYNC_TRIG  = 8'b1111_1001;
	// own code here, so it differs from SyncForTrig
	localparam logic [7:0] CMD_L1A_CR     = 8'b1111_0010;
	localparam logic [7:0] CMD_CHARGE_INJ = 8'b1111_0100;
	localparam logic [7:0] CMD_L1A        = 8'b1111_0110;
	localparam logic [7:0] CMD_L1A_BCR    = 8'b1111_0011;
	localparam logic [7:0] CMD_WS_START   = 8'b1111_1100;
	localparam logic [7:0] CMD_WS_STOP    = 8'b1111_1010;

	//////////////////////////////
	// one-hot bit positions in fcd
	//////////////////////////////
	localparam int NUM_CMD        = 10;
	localparam int IDX_IDLE       = 0;
	localparam int IDX_LINK_RST   = 1;
	localparam int IDX_BCR        = 2;
	localparam int IDX_SYNC_TRIG  = 3;
	localparam int IDX_L1A_CR     = 4;
	localparam int IDX_CHARGE_INJ = 5;
	localparam int IDX_L1A        = 6;
	localparam int IDX_L1A_BCR    = 7;
	localparam int IDX_WS_START   = 8;
	localparam int IDX_WS_STOP    = 9;

	// counters, last bunch of an orbit
	localparam int BX_MAX     = 3563;
	localparam int BX_WIDTH   = 12;
	localparam int EVT_WIDTH  = 12;
	// trigger record is {bunch id, event id}
	localparam int TRIG_WIDTH = BX_WIDTH + EVT_WIDTH;

	// trigger queue and credit loop
	localparam int QUEUE_DEPTH  = 4;
	localparam int INIT_CREDITS = 4;

	// word alignment
	localparam int LOCK_COUNT = 4;
	localparam int SLIP_WAIT  = 3;

endpackage

//--- src/fcAligner.sv
// word aligner, slips the bit offset of the raw stream until the decoder sees idles, then locks
module fcAligner (
	input  logic       clk40_aligned,
	input  logic       rstn,
	input  logic       alignMode,
	input  logic [7:0] rawWord,
	input  logic       idleSeen,
	output logic [7:0] alignedWord,
	output logic       aligned
);

	// last raw word, for windows across the word boundary
	logic [7:0] prevWord;
	// bit offset into {prevWord, rawWord}
	logic [2:0] slip;
	// settle cycles since the last slip
	logic [$clog2(fcPkg::SLIP_WAIT)-1:0] waitCnt;
	// consecutive idle reports
	logic [$clog2(fcPkg::LOCK_COUNT)-1:0] idleCnt;
	// alignMode one cycle late, for its rising edge
	logic modeQ;
	logic [15:0] wordPair;

	assign wordPair = {prevWord, rawWord};

	//////////////////////////////
	// datapath
	//////////////////////////////
	// offset k takes bits k..k+7 of the pair
	always_ff @(posedge clk40_aligned) begin
		prevWord    <= rawWord;
		alignedWord <= wordPair[slip +: 8];
	end

	//////////////////////////////
	// slip / lock control
	//////////////////////////////
	always_ff @(posedge clk40_aligned) begin
		if (!rstn) begin
			slip    <= '0;
			waitCnt <= '0;
			idleCnt <= '0;
			aligned <= 1'b0;
			modeQ   <= 1'b0;
		end else begin
			modeQ <= alignMode;
			if (alignMode && !modeQ) begin
				// fresh request, drop lock and hunt again from the current offset
				aligned <= 1'b0;
				waitCnt <= '0;
				idleCnt <= '0;
			end else if (alignMode && !aligned) begin
				if (waitCnt != fcPkg::SLIP_WAIT - 1) begin
					// idleSeen still reflects the old offset
					waitCnt <= waitCnt + 1'b1;
				end else if (idleSeen) begin
					if (idleCnt == fcPkg::LOCK_COUNT - 1) begin
						aligned <= 1'b1;
					end else begin
						idleCnt <= idleCnt + 1'b1;
					end
				end else begin
					// no idle here, try next bit
					slip    <= slip + 3'd1;
					waitCnt <= '0;
					idleCnt <= '0;
				end
			end
		end
	end

	// offset frozen whenever self-alignment is off
	assert property (@(posedge clk40_aligned) disable iff (!rstn)
		!alignMode |=> $stable(slip));

endmodule

//--- src/fcDecoder.sv
// fast command decoder, maps each aligned word to a one-hot command or reports idles during alignment
module fcDecoder (
	input  logic                      clk40_aligned,
	input  logic                      rstn,
	input  logic                      selfWordAlignOn,
	input  logic [7:0]                fcReg,
	output logic                      selfAlignIdleDec,
	output logic [fcPkg::NUM_CMD-1:0] fcd
);

	// one-hot image of fcReg, zero for unknown codes
	logic [fcPkg::NUM_CMD-1:0] cmdOneHot;

	//////////////////////////////
	// code lookup
	//////////////////////////////
	always_comb begin
		cmdOneHot = '0;
		case (fcReg)
			fcPkg::CMD_IDLE:       cmdOneHot[fcPkg::IDX_IDLE]       = 1'b1;
			fcPkg::CMD_LINK_RST:   cmdOneHot[fcPkg::IDX_LINK_RST]   = 1'b1;
			fcPkg::CMD_BCR:        cmdOneHot[fcPkg::IDX_BCR]        = 1'b1;
			fcPkg::CMD_SYNC_TRIG:  cmdOneHot[fcPkg::IDX_SYNC_TRIG]  = 1'b1;
			fcPkg::CMD_L1A_CR:     cmdOneHot[fcPkg::IDX_L1A_CR]     = 1'b1;
			fcPkg::CMD_CHARGE_INJ: cmdOneHot[fcPkg::IDX_CHARGE_INJ] = 1'b1;
			fcPkg::CMD_L1A:        cmdOneHot[fcPkg::IDX_L1A]        = 1'b1;
			fcPkg::CMD_L1A_BCR:    cmdOneHot[fcPkg::IDX_L1A_BCR]    = 1'b1;
			fcPkg::CMD_WS_START:   cmdOneHot[fcPkg::IDX_WS_START]   = 1'b1;
			fcPkg::CMD_WS_STOP:    cmdOneHot[fcPkg::IDX_WS_STOP]    = 1'b1;
			// anything else decodes to nothing
			default:               cmdOneHot = '0;
		endcase
	end

	//////////////////////////////
	// output register
	//////////////////////////////
	always_ff @(posedge clk40_aligned) begin
		if (!rstn) begin
			selfAlignIdleDec <= 1'b0;
			fcd              <= '0;
		end else if (selfWordAlignOn) begin
			// alignment mode, only the idle flag, no commands pass
			selfAlignIdleDec <= (fcReg == fcPkg::CMD_IDLE);
			fcd              <= '0;
		end else begin
			selfAlignIdleDec <= 1'b0;
			fcd              <= cmdOneHot;
		end
	end

	// executor relies on a single command per cycle
	assert property (@(posedge clk40_aligned) disable iff (!rstn) $onehot0(fcd));

endmodule

//--- src/fcExecute.sv
// command executor, keeps bunch and event counters, sampler window and pulses, emits L1A records
module fcExecute (
	input  logic                         clk40_aligned,
	input  logic                         rstn,
	input  logic [fcPkg::NUM_CMD-1:0]    fcd,
	output logic                         linkRst,
	output logic                         chargeInj,
	output logic                         syncForTrig,
	output logic                         wsActive,
	output logic                         l1aPush,
	output logic [fcPkg::BX_WIDTH-1:0]   bunchId,
	output logic [fcPkg::TRIG_WIDTH-1:0] l1aRecord
);

	// L1A event number
	logic [fcPkg::EVT_WIDTH-1:0] evtCnt;
	// commands sharing an action
	logic isL1a;
	logic isBcr;

	// L1A_BCR counts as both
	assign isL1a = fcd[fcPkg::IDX_L1A] | fcd[fcPkg::IDX_L1A_BCR];
	assign isBcr = fcd[fcPkg::IDX_BCR] | fcd[fcPkg::IDX_L1A_BCR];

	//////////////////////////////
	// counters, window, pulses
	//////////////////////////////
	// idle bit of fcd has no action
	always_ff @(posedge clk40_aligned) begin
		if (!rstn) begin
			bunchId     <= '0;
			evtCnt      <= '0;
			linkRst     <= 1'b0;
			chargeInj   <= 1'b0;
			syncForTrig <= 1'b0;
			wsActive    <= 1'b0;
			l1aPush     <= 1'b0;
		end else begin
			// bunch counter, wraps at end of orbit
			if (isBcr || bunchId == fcPkg::BX_MAX) begin
				bunchId <= '0;
			end else begin
				bunchId <= bunchId + 1'b1;
			end
			// event counter, clear wins
			if (fcd[fcPkg::IDX_L1A_CR]) begin
				evtCnt <= '0;
			end else if (isL1a) begin
				evtCnt <= evtCnt + 1'b1;
			end
			// sampler window level
			if (fcd[fcPkg::IDX_WS_START]) begin
				wsActive <= 1'b1;
			end else if (fcd[fcPkg::IDX_WS_STOP]) begin
				wsActive <= 1'b0;
			end
			// single-cycle pulses
			linkRst     <= fcd[fcPkg::IDX_LINK_RST];
			chargeInj   <= fcd[fcPkg::IDX_CHARGE_INJ];
			syncForTrig <= fcd[fcPkg::IDX_SYNC_TRIG];
			l1aPush     <= isL1a;
		end
	end

	// record takes the bunch id before any BCR of the same command
	always_ff @(posedge clk40_aligned) begin
		if (isL1a) begin
			l1aRecord <= {bunchId, evtCnt};
		end
	end

	assert property (@(posedge clk40_aligned) disable iff (!rstn) bunchId <= fcPkg::BX_MAX);

endmodule

//--- src/trigQueue.sv
// trigger record FIFO, sends the oldest L1A record downstream while the receiver holds credits
module trigQueue (
	input  logic                         clk40_aligned,
	input  logic                         rstn,
	input  logic                         push,
	input  logic                         creditReturn,
	input  logic [fcPkg::TRIG_WIDTH-1:0] pushData,
	output logic                         trigValid,
	output logic                         overflow,
	output logic [fcPkg::TRIG_WIDTH-1:0] trigData
);

	// record storage
	logic [fcPkg::TRIG_WIDTH-1:0] mem [fcPkg::QUEUE_DEPTH];
	logic [$clog2(fcPkg::QUEUE_DEPTH)-1:0] wrPtr;
	logic [$clog2(fcPkg::QUEUE_DEPTH)-1:0] rdPtr;
	// entries held, 0..QUEUE_DEPTH
	logic [$clog2(fcPkg::QUEUE_DEPTH+1)-1:0] count;
	// credits left at the receiver
	logic [$clog2(fcPkg::INIT_CREDITS+1)-1:0] credits;
	logic full;
	logic doPush;
	logic doSend;

	// full queue drops the push, even if a send goes out the same cycle
	assign full   = (count == fcPkg::QUEUE_DEPTH);
	assign doPush = push && !full;
	// show-ahead, head record is on trigData whenever valid
	assign doSend    = (count != '0) && (credits != '0);
	assign trigValid = doSend;
	assign trigData  = mem[rdPtr];

	always_ff @(posedge clk40_aligned) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	//////////////////////////////
	// pointers, fill level, credits
	//////////////////////////////
	always_ff @(posedge clk40_aligned) begin
		if (!rstn) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			credits  <= $bits(credits)'(fcPkg::INIT_CREDITS);
			overflow <= 1'b0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doSend) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doSend})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// sticky until reset
			if (push && full) begin
				overflow <= 1'b1;
			end
			// send and return together leave the count alone
			if (doSend && !creditReturn) begin
				credits <= credits - 1'b1;
			end else if (!doSend && creditReturn && credits != fcPkg::INIT_CREDITS) begin
				credits <= credits + 1'b1;
			end
		end
	end

	assert property (@(posedge clk40_aligned) disable iff (!rstn)
		credits <= fcPkg::INIT_CREDITS);
	assert property (@(posedge clk40_aligned) disable iff (!rstn) trigValid |-> credits != '0);

endmodule

//--- src/fastCmdRx.sv
// fast-command receive top, chains aligner, decoder, executor and trigger queue
module fastCmdRx (
	input  logic                         clk40_aligned,
	input  logic                         rstn,
	input  logic [7:0]                   rawWord,
	input  logic                         alignMode,
	input  logic                         creditReturn,
	output logic                         aligned,
	output logic                         linkRst,
	output logic                         chargeInj,
	output logic                         syncForTrig,
	output logic                         wsActive,
	output logic [fcPkg::BX_WIDTH-1:0]   bunchId,
	output logic                         trigValid,
	output logic [fcPkg::TRIG_WIDTH-1:0] trigData,
	output logic                         overflow
);

	// aligner <-> decoder
	logic [7:0] alignedWord;
	logic       idleSeen;
	// decoder -> executor
	logic [fcPkg::NUM_CMD-1:0] fcd;
	// executor -> queue
	logic                         l1aPush;
	logic [fcPkg::TRIG_WIDTH-1:0] l1aRecord;

	//////////////////////////////
	// decode stage
	//////////////////////////////
	fcAligner fcAligner_i (
		.clk40_aligned (clk40_aligned),
		.rstn          (rstn),
		.alignMode     (alignMode),
		.rawWord       (rawWord),
		.idleSeen      (idleSeen),
		.alignedWord   (alignedWord),
		.aligned       (aligned)
	);

	// decoder stays in idle-report mode for as long as alignMode is high
	fcDecoder fcDecoder_i (
		.clk40_aligned    (clk40_aligned),
		.rstn             (rstn),
		.selfWordAlignOn  (alignMode),
		.fcReg            (alignedWord),
		.selfAlignIdleDec (idleSeen),
		.fcd              (fcd)
	);

	// execute stage
	fcExecute fcExecute_i (
		.clk40_aligned (clk40_aligned),
		.rstn          (rstn),
		.fcd           (fcd),
		.linkRst       (linkRst),
		.chargeInj     (chargeInj),
		.syncForTrig   (syncForTrig),
		.wsActive      (wsActive),
		.l1aPush       (l1aPush),
		.bunchId       (bunchId),
		.l1aRecord     (l1aRecord)
	);

	// result stage
	trigQueue trigQueue_i (
		.clk40_aligned (clk40_aligned),
		.rstn          (rstn),
		.push          (l1aPush),
		.creditReturn  (creditReturn),
		.pushData      (l1aRecord),
		.trigValid     (trigValid),
		.overflow      (overflow),
		.trigData      (trigData)
	);

endmodule

//--- test/tbClock.sv
// testbench clock and reset source, 40 unit period, reset held low over the first two rising edges
module tbClock (
	output logic clk40_aligned,
	output logic rstn
);

	localparam int HALF_PERIOD = 20;

	initial begin
		clk40_aligned = 1'b0;
		forever #HALF_PERIOD clk40_aligned = ~clk40_aligned;
	end

	// released on the second rising edge, first active edge is the third
	initial begin
		rstn = 1'b0;
		repeat (2) @(posedge clk40_aligned);
		rstn <= 1'b1;
	end

endmodule

//--- test/fastCmdRxTb.sv
// testbench for the fast-command receive path, replays the stimulus file against a cycle model
module fastCmdRxTb;

	// line rotation of the serial stream, in bits
	localparam int LINE_ROT = 5;
	localparam STIM_FILE = "test/fcStimulus.txt";

	logic                         clk40_aligned;
	logic                         rstn;
	logic [7:0]                   rawWord;
	logic                         alignMode;
	logic                         creditReturn;
	logic                         aligned;
	logic                         linkRst;
	logic                         chargeInj;
	logic                         syncForTrig;
	logic                         wsActive;
	logic [fcPkg::BX_WIDTH-1:0]   bunchId;
	logic                         trigValid;
	logic [fcPkg::TRIG_WIDTH-1:0] trigData;
	logic                         overflow;

	// per-cycle stimulus, words as sent before the rotation
	logic [7:0] sentWord[$];
	logic       modeAt[$];
	logic       creditAt[$];
	// -1 for a clock cycle, otherwise index of a test end
	int entries[$];
	int endTest[$];
	int endPulses[$];
	int endSent[$];
	int endOvf[$];
	int endAligned[$];

	//////////////////////////////
	// reference model state
	//////////////////////////////
	logic [fcPkg::BX_WIDTH-1:0]   bx = '0;
	logic [fcPkg::EVT_WIDTH-1:0]  evt = '0;
	logic                         ws = 1'b0;
	logic                         pushQ = 1'b0;
	logic [fcPkg::TRIG_WIDTH-1:0] recQ = '0;
	logic [fcPkg::TRIG_WIDTH-1:0] fifo[$];
	int                           credits = fcPkg::INIT_CREDITS;
	logic                         expOvf = 1'b0;
	logic                         expLink = 1'b0;
	logic                         expCharge = 1'b0;
	logic                         expSync = 1'b0;
	logic                         expValid = 1'b0;

	// bookkeeping
	int errors = 0;
	int errStart = 0;
	int pulseCnt = 0;
	int sentCnt = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCnt = 0;
	int cycleLimit = 0;

	tbClock clockGen (
		.clk40_aligned (clk40_aligned),
		.rstn          (rstn)
	);

	fastCmdRx fastCmdRx_i (
		.clk40_aligned (clk40_aligned),
		.rstn          (rstn),
		.rawWord       (rawWord),
		.alignMode     (alignMode),
		.creditReturn  (creditReturn),
		.aligned       (aligned),
		.linkRst       (linkRst),
		.chargeInj     (chargeInj),
		.syncForTrig   (syncForTrig),
		.wsActive      (wsActive),
		.bunchId       (bunchId),
		.trigValid     (trigValid),
		.trigData      (trigData),
		.overflow      (overflow)
	);

	task automatic loadStimulus();
		int fd;
		int n;
		int kind;
		int test;
		int a;
		int b;
		int c;
		int d;
		string line;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", STIM_FILE);
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			n = $sscanf(line, "%d %d %h %d %d %d", kind, test, a, b, c, d);
			// comments and blank lines do not scan
			if (n == 6 && kind == 0) begin
				repeat (d) begin
					sentWord.push_back(a[7:0]);
					modeAt.push_back(b[0]);
					creditAt.push_back(c[0]);
					entries.push_back(-1);
				end
			end else if (n == 6) begin
				entries.push_back(endTest.size());
				endTest.push_back(test);
				endPulses.push_back(a);
				endSent.push_back(b);
				endOvf.push_back(c);
				endAligned.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// raw word k carries the tail of word k and the head of word k+1
	function automatic logic [7:0] rotateWord(input int k);
		logic [15:0] pair;
		logic [7:0]  nextWord;
		nextWord = (k + 1 < sentWord.size()) ? sentWord[k+1] : fcPkg::CMD_IDLE;
		pair = {sentWord[k], nextWord};
		return 8'(pair >> (8 - LINE_ROT));
	endfunction

	// word k-3 acts at edge k, unless self-alignment was on when the decoder took it
	function automatic logic [7:0] commandAt(input int k);
		if (k < 3 || modeAt[k-2]) begin
			return 8'h00;
		end
		return sentWord[k-3];
	endfunction

	//////////////////////////////
	// one clock edge of the model
	//////////////////////////////
	task automatic stepModel(input int k);
		logic [7:0] cmd;
		logic ret;
		logic send;
		logic full;
		cmd  = commandAt(k);
		ret  = (k > 0) ? creditAt[k-1] : 1'b0;
		send = (fifo.size() != 0) && (credits != 0);
		full = (fifo.size() == fcPkg::QUEUE_DEPTH);
		// queue, all decisions on the state before the edge
		if (send) fifo.delete(0);
		if (pushQ && full) expOvf = 1'b1;
		if (pushQ && !full) fifo.push_back(recQ);
		if (send && !ret) begin
			credits--;
		end else if (!send && ret && credits < fcPkg::INIT_CREDITS) begin
			credits++;
		end
		// executor
		pushQ = (cmd == fcPkg::CMD_L1A) || (cmd == fcPkg::CMD_L1A_BCR);
		if (pushQ) recQ = {bx, evt};
		if (cmd == fcPkg::CMD_L1A_CR) begin
			evt = '0;
		end else if (pushQ) begin
			evt = evt + 1'b1;
		end
		if (cmd == fcPkg::CMD_WS_START) ws = 1'b1;
		if (cmd == fcPkg::CMD_WS_STOP) ws = 1'b0;
		expLink   = (cmd == fcPkg::CMD_LINK_RST);
		expCharge = (cmd == fcPkg::CMD_CHARGE_INJ);
		expSync   = (cmd == fcPkg::CMD_SYNC_TRIG);
		if (cmd == fcPkg::CMD_BCR || cmd == fcPkg::CMD_L1A_BCR || bx == fcPkg::BX_MAX) begin
			bx = '0;
		end else begin
			bx = bx + 1'b1;
		end
		expValid = (fifo.size() != 0) && (credits != 0);
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		$display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		errors++;
	endtask

	task automatic checkOutputs();
		assert (bunchId == bx) else reportMismatch("bunchId", bunchId, bx);
		assert (linkRst == expLink) else reportMismatch("linkRst", linkRst, expLink);
		assert (chargeInj == expCharge) else reportMismatch("chargeInj", chargeInj, expCharge);
		assert (syncForTrig == expSync) else reportMismatch("syncForTrig", syncForTrig, expSync);
		assert (wsActive == ws) else reportMismatch("wsActive", wsActive, ws);
		assert (trigValid == expValid) else reportMismatch("trigValid", trigValid, expValid);
		assert (overflow == expOvf) else reportMismatch("overflow", overflow, expOvf);
		if (expValid) begin
			assert (trigData == fifo[0]) else reportMismatch("trigData", trigData, fifo[0]);
		end
		// counts from the DUT side
		pulseCnt += int'(linkRst) + int'(chargeInj) + int'(syncForTrig);
		if (trigValid) sentCnt++;
	endtask

	task automatic closeTest(input int e);
		int bad;
		assert (pulseCnt == endPulses[e])
			else reportMismatch("pulse count", pulseCnt, endPulses[e]);
		assert (sentCnt == endSent[e]) else reportMismatch("records sent", sentCnt, endSent[e]);
		assert (overflow == endOvf[e]) else reportMismatch("overflow", overflow, endOvf[e]);
		assert (aligned == endAligned[e]) else reportMismatch("aligned", aligned, endAligned[e]);
		bad = errors - errStart;
		testsRun++;
		if (bad != 0) testsFailed++;
		$display("test %0d %s, %0d errors", endTest[e], (bad == 0) ? "passed" : "failed", bad);
		errStart = errors;
		pulseCnt = 0;
		sentCnt  = 0;
	endtask

	// run limit
	always @(posedge clk40_aligned) begin
		cycleCnt++;
		if (cycleLimit > 0 && cycleCnt > cycleLimit) begin
			$display("timeout, the run did not finish within %0d cycles", cycleLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		int k;
		int e;
		rawWord      = '0;
		alignMode    = 1'b0;
		creditReturn = 1'b0;
		loadStimulus();
		cycleLimit = 2 * sentWord.size() + 100;
		wait (rstn === 1'b1);
		k = 0;
		foreach (entries[i]) begin
			e = entries[i];
			if (e < 0) begin
				@(posedge clk40_aligned);
				rawWord      <= rotateWord(k);
				alignMode    <= modeAt[k];
				creditReturn <= creditAt[k];
				stepModel(k);
				// outputs settled after the edge
				@(negedge clk40_aligned);
				checkOutputs();
				k++;
			end else begin
				closeTest(e);
			end
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			testsRun, testsRun - testsFailed, testsFailed, errors);
		if (errors == 0 && testsFailed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- test/fcStimulus.txt
// kind 0, one clock per repeat: kind test word mode credit repeat, word in hex before line rotation
// kind 1, end of test: kind test pulses sent overflow aligned, counts are single digits
// 1 lock on an idle stream, then idles with self-alignment off
0 1 f0 1 0 60
0 1 f0 0 0 8
1 1 0 0 0 1
// 2 BCR, a whole orbit with its wrap, then L1A_BCR and one credit back
0 2 f1 0 0 1
0 2 f0 0 0 3570
0 2 f3 0 0 1
0 2 f0 0 0 6
0 2 f0 0 1 1
0 2 f0 0 0 8
1 2 0 1 0 1
// 3 pulses, sampler window, unknown codes
0 3 f8 0 0 1
0 3 f0 0 0 1
0 3 f4 0 0 1
0 3 f0 0 0 1
0 3 f9 0 0 1
0 3 fc 0 0 1
0 3 f0 0 0 3
0 3 fa 0 0 1
0 3 55 0 0 1
0 3 ff 0 0 1
0 3 f0 0 0 8
1 3 3 0 0 1
// 4 records, L1A_CR restarts the event ids
0 4 f6 0 0 1
0 4 f0 0 0 6
0 4 f0 0 1 1
0 4 f6 0 0 1
0 4 f0 0 0 6
0 4 f0 0 1 1
0 4 f2 0 0 1
0 4 f0 0 0 2
0 4 f6 0 0 1
0 4 f0 0 0 6
0 4 f0 0 1 1
0 4 f0 0 0 8
1 4 0 3 0 1
// 5 credits run out, four held, a fifth overflows, returns release them
0 5 f6 0 0 4
0 5 f0 0 0 6
0 5 f6 0 0 4
0 5 f0 0 0 2
0 5 f6 0 0 1
0 5 f0 0 0 6
0 5 f0 0 1 4
0 5 f0 0 0 8
1 5 0 8 1 1

//--- list.f
src/fcPkg.sv
src/fcAligner.sv
src/fcDecoder.sv
src/fcExecute.sv
src/trigQueue.sv
src/fastCmdRx.sv
test/tbClock.sv
test/fastCmdRxTb.sv
